//--- logic/rs485_consts.svh
/*
 * RS-485 serial port timing constants
 * bit period and transceiver turnaround timing, all in clock cycles
 */
`ifndef RS485_CONSTS_SVH
`define RS485_CONSTS_SVH

// clock cycles per serial bit, the one fixed bit rate of the port
`define RS485_CLKS_PER_BIT 16

// time the driver and receiver need to switch direction
// must be 2 or more since it also sets the depth of the transmit delay line
`define RS485_SWITCH_CYCLES 4

// idle level is driven this long after the last stop bit before the driver turns off
`define RS485_END_CYCLES 4

`endif

//--- logic/rs485_ctrl.sv
/*
 * RS-485 transceiver control
 * switches driver and receiver enables around each transmission, delays the
 * transmit data behind the driver enable and blanks the receive line meanwhile
 */
`timescale 1ns/1ps
`include "rs485_consts.svh"

module rs485_ctrl #(
  parameter int unsigned TransceiverSwitchCycles = `RS485_SWITCH_CYCLES,
  parameter int unsigned TransmitEndCycles       = `RS485_END_CYCLES
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic tx_i,
  output logic rx_o,
  input  logic rx_enable_i,
  input  logic tx_enable_i,
  output logic di_o,
  output logic ren_o,
  output logic de_o,
  input  logic ro_i
);
  // the data reaches the pin TransceiverSwitchCycles late, so the driver has to stay on
  // for that long on top of the idle drive time
  localparam int unsigned CooldownCycles = TransceiverSwitchCycles + TransmitEndCycles;
  localparam int unsigned CntW           = $clog2(CooldownCycles + 1);

  typedef enum logic [1:0] {
    rx_idle,
    tx_active,
    tx_cooldown,
    rx_start_wait
  } ctrl_state_e;

  ctrl_state_e                        state_q, state_d;
  logic [CntW-1:0]                    cnt_q, cnt_d;
  logic [TransceiverSwitchCycles-1:0] delay_q;
  logic                               de_q, de_d;
  logic                               ren_q, ren_d;
  logic                               rx_q;
  logic                               gate;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    de_d    = de_q;
    ren_d   = ren_q;
    gate    = 1'b0;

    case (state_q)
      rx_idle: begin
        // listening, receiver follows the host's enable
        de_d  = 1'b0;
        ren_d = ~rx_enable_i;
      end
      tx_active: begin
        de_d  = 1'b1;
        ren_d = 1'b1;
        gate  = 1'b1;
        if (!tx_enable_i) begin
          cnt_d   = CntW'(CooldownCycles);
          state_d = tx_cooldown;
        end
      end
      tx_cooldown: begin
        // delayed frame tail and idle level still leaving through the driver
        gate = 1'b1;
        if (cnt_q != '0) begin
          de_d  = 1'b1;
          ren_d = 1'b1;
          cnt_d = cnt_q - 1'b1;
        end else begin
          de_d    = 1'b0;
          ren_d   = ~rx_enable_i;
          cnt_d   = CntW'(TransceiverSwitchCycles);
          state_d = rx_start_wait;
        end
      end
      rx_start_wait: begin
        // receiver is waking up, keep its output hidden until it settles
        de_d  = 1'b0;
        ren_d = ~rx_enable_i;
        if (cnt_q != '0) begin
          gate  = 1'b1;
          cnt_d = cnt_q - 1'b1;
        end else begin
          state_d = rx_idle;
        end
      end
      default: state_d = rx_idle;
    endcase

    // a new frame wins from any other state, so back-to-back frames keep the driver on
    if ((state_q != tx_active) && tx_enable_i) begin
      de_d    = 1'b1;
      ren_d   = 1'b1;
      gate    = 1'b1;
      state_d = tx_active;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= rx_idle;
      cnt_q   <= '0;
      de_q    <= 1'b0;
      ren_q   <= 1'b1;
      rx_q    <= 1'b1;
      delay_q <= '1;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      de_q    <= de_d;
      ren_q   <= ren_d;
      // registered so that enable switching cannot glitch the receive stage
      rx_q    <= gate ? 1'b1 : ro_i;
      // transmit line delayed so the start bit trails the driver enable
      delay_q <= {delay_q[TransceiverSwitchCycles-2:0], tx_i};
    end
  end

  assign di_o  = delay_q[TransceiverSwitchCycles-1];
  assign de_o  = de_q;
  assign ren_o = ren_q;
  assign rx_o  = rx_q;
endmodule

//--- logic/rs485_pkg.sv
/*
 * RS-485 serial port types
 * payload structs passed between the UART stages and the host ports
 */
package rs485_pkg;

  // one byte handed over by the host for transmission
  typedef struct packed {
    logic [7:0] data;
  } tx_byte_t;

  // one received byte with its status flags
  typedef struct packed {
    // payload in the order it came off the line, bit 0 first
    logic [7:0] data;
    // stop bit was sampled low
    logic       frame_err;
    // at least one frame was lost because the host had not taken the word yet
    logic       overrun;
  } rx_word_t;

endpackage

//--- logic/rs485_uart_top.sv
/*
 * RS-485 UART subsystem
 * host byte ports on one side, transceiver pins on the other
 */
`timescale 1ns/1ps

module rs485_uart_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                tx_req_i,
  input  rs485_pkg::tx_byte_t tx_data_i,
  output logic                tx_ack_o,
  output logic                rx_req_o,
  output rs485_pkg::rx_word_t rx_word_o,
  input  logic                rx_ack_i,
  input  logic                rx_enable_i,
  output logic                di_o,
  output logic                de_o,
  output logic                ren_o,
  input  logic                ro_i
);
  logic tx_line;
  logic tx_busy;
  logic rx_line;

  // serializer, its busy flag tells the transceiver control when to drive
  uart_tx_stage u_tx (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (tx_req_i),
    .data_i (tx_data_i),
    .ack_o  (tx_ack_o),
    .line_o (tx_line),
    .busy_o (tx_busy)
  );

  rs485_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .tx_i        (tx_line),
    .rx_o        (rx_line),
    .rx_enable_i (rx_enable_i),
    .tx_enable_i (tx_busy),
    .di_o        (di_o),
    .ren_o       (ren_o),
    .de_o        (de_o),
    .ro_i        (ro_i)
  );

  // sees only the gated line, never the port's own frames
  uart_rx_stage u_rx (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .line_i (rx_line),
    .req_o  (rx_req_o),
    .word_o (rx_word_o),
    .ack_i  (rx_ack_i)
  );
endmodule

//--- logic/uart_rx_stage.sv
/*
 * UART receive stage
 * recovers 8N1 frames from the gated line and offers each word to the host
 * by four-phase handshake, with framing and overrun flags
 */
`timescale 1ns/1ps
`include "rs485_consts.svh"

module uart_rx_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                line_i,
  output logic                req_o,
  output rs485_pkg::rx_word_t word_o,
  input  logic                ack_i
);
  import rs485_pkg::*;

  localparam int unsigned ClksPerBit = `RS485_CLKS_PER_BIT;
  localparam int unsigned HalfBit    = ClksPerBit / 2;
  localparam int unsigned CycW       = $clog2(ClksPerBit);

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_bits,
    rx_tail
  } rx_state_e;

  rx_state_e       state_q;
  logic [CycW-1:0] cyc_q;
  logic [3:0]      bit_q;
  logic            line_q;
  logic            req_q;
  logic            lost_q;
  logic [8:0]      shift_q;
  rx_word_t        word_q;
  logic            fall;
  logic            start_mid;
  logic            bit_mid;
  logic            frame_done;
  logic            deliver;
  logic            drop;

  assign fall      = line_q && !line_i;
  assign start_mid = (state_q == rx_start) && (cyc_q == CycW'(HalfBit - 1));
  assign bit_mid   = (state_q == rx_bits) && (cyc_q == CycW'(ClksPerBit - 1));
  // ends one cycle before the stop bit does, so a back-to-back start edge is still caught
  assign frame_done = (state_q == rx_tail) && (cyc_q == CycW'(HalfBit - 2));
  // the output is free only once the previous handshake has fully completed
  assign deliver    = frame_done && !req_q && !ack_i;
  assign drop       = frame_done && !deliver;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= rx_idle;
      cyc_q   <= '0;
      bit_q   <= '0;
      line_q  <= 1'b1;
      req_q   <= 1'b0;
      lost_q  <= 1'b0;
    end else begin
      line_q <= line_i;
      case (state_q)
        rx_idle: begin
          if (fall) begin
            cyc_q   <= '0;
            state_q <= rx_start;
          end
        end
        rx_start: begin
          // a line back high at mid start bit was only a glitch
          if (start_mid) begin
            cyc_q   <= '0;
            bit_q   <= '0;
            state_q <= line_i ? rx_idle : rx_bits;
          end else begin
            cyc_q <= cyc_q + 1'b1;
          end
        end
        rx_bits: begin
          // eight data bits then the stop bit, each sampled at mid-bit
          if (bit_mid) begin
            cyc_q <= '0;
            bit_q <= bit_q + 4'd1;
            if (bit_q == 4'd8) begin
              state_q <= rx_tail;
            end
          end else begin
            cyc_q <= cyc_q + 1'b1;
          end
        end
        rx_tail: begin
          if (frame_done) begin
            state_q <= rx_idle;
          end else begin
            cyc_q <= cyc_q + 1'b1;
          end
        end
        default: state_q <= rx_idle;
      endcase

      if (deliver) begin
        req_q <= 1'b1;
      end else if (req_q && ack_i) begin
        req_q <= 1'b0;
      end

      // a loss after req has fallen but before ack has fallen is reported on the next word
      if (deliver) begin
        lost_q <= 1'b0;
      end else if (drop && !req_q) begin
        lost_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bit_mid) begin
      shift_q <= {line_i, shift_q[8:1]};
    end
    if (deliver) begin
      word_q.data      <= shift_q[7:0];
      word_q.frame_err <= ~shift_q[8];
      word_q.overrun   <= lost_q;
    end else if (drop && req_q) begin
      // the waiting word is kept and only flags that a later frame was lost
      word_q.overrun <= 1'b1;
    end
  end

  assign req_o  = req_q;
  assign word_o = word_q;
endmodule

//--- logic/uart_tx_stage.sv
/*
 * UART transmit stage
 * takes one byte per four-phase handshake and sends it as an 8N1 frame
 */
`timescale 1ns/1ps
`include "rs485_consts.svh"

module uart_tx_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  input  rs485_pkg::tx_byte_t data_i,
  output logic                ack_o,
  output logic                line_o,
  output logic                busy_o
);
  import rs485_pkg::*;

  localparam int unsigned ClksPerBit = `RS485_CLKS_PER_BIT;
  localparam int unsigned CycW       = (ClksPerBit > 1) ? $clog2(ClksPerBit) : 1;

  typedef enum logic [1:0] {
    tx_idle,
    tx_frame,
    tx_done
  } tx_state_e;

  tx_state_e       state_q;
  logic [3:0]      bit_q;
  logic [CycW-1:0] cyc_q;
  logic            line_q;
  logic            busy_q;
  logic            ack_q;
  tx_byte_t        byte_q;
  logic            start;
  logic            bit_end;

  // a request seen in idle starts a frame on the next cycle
  assign start   = (state_q == tx_idle) && req_i;
  // last cycle of the bit currently on the line
  assign bit_end = (state_q == tx_frame) && (cyc_q == CycW'(ClksPerBit - 1));

  // bit_q counts the bit on the line, 0 is the start bit, 1 to 8 data, 9 the stop bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= tx_idle;
      bit_q   <= '0;
      cyc_q   <= '0;
      line_q  <= 1'b1;
      busy_q  <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      case (state_q)
        tx_idle: begin
          if (req_i) begin
            // start bit goes out right away
            state_q <= tx_frame;
            bit_q   <= '0;
            cyc_q   <= '0;
            line_q  <= 1'b0;
            busy_q  <= 1'b1;
          end
        end
        tx_frame: begin
          if (bit_end) begin
            cyc_q <= '0;
            bit_q <= bit_q + 4'd1;
            if (bit_q < 4'd8) begin
              line_q <= byte_q.data[0];
            end else if (bit_q == 4'd8) begin
              line_q <= 1'b1;
            end else begin
              // stop bit is over, line is left at idle
              state_q <= tx_done;
              busy_q  <= 1'b0;
              ack_q   <= 1'b1;
            end
          end else begin
            cyc_q <= cyc_q + 1'b1;
          end
        end
        tx_done: begin
          // hold ack until the host drops its request
          if (!req_i) begin
            ack_q   <= 1'b0;
            state_q <= tx_idle;
          end
        end
        default: state_q <= tx_idle;
      endcase
    end
  end

  // byte register doubles as the shifter, LSB is always the next data bit to send
  always_ff @(posedge clk_i) begin
    if (start) begin
      byte_q <= data_i;
    end else if (bit_end && (bit_q < 4'd8)) begin
      byte_q.data <= {1'b0, byte_q.data[7:1]};
    end
  end

  assign ack_o  = ack_q;
  assign line_o = line_q;
  assign busy_o = busy_q;
endmodule

//--- rs485_uart.f
+incdir+logic
logic/rs485_pkg.sv
logic/uart_tx_stage.sv
logic/rs485_ctrl.sv
logic/uart_rx_stage.sv
logic/rs485_uart_top.sv
sim/rs485_uart_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the rs485_uart testbench with Verilator, runs it and reads the verdict from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --assert -Wno-fatal -j 0 \
  --top-module rs485_uart_tb -o rs485_uart_sim \
  -f rs485_uart.f > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }
./obj_dir/rs485_uart_sim > sim.log 2>&1 \
  || echo "simulator exited with an error status"
cat sim.log
grep -q "Simulation finished: PASS" sim.log \
  && { echo "run_sim: passed"; exit 0; } \
  || { echo "run_sim: failed, see sim.log"; exit 1; }

//--- sim/rs485_uart_tb.sv
/*
 * RS-485 UART testbench
 * drives both host ports and a remote node on ro_i, decodes frames on di_o
 */
`timescale 1ns/1ps
`include "rs485_consts.svh"

module rs485_uart_tb;
  import rs485_pkg::*;

  localparam int Cpb      = `RS485_CLKS_PER_BIT;
  localparam int SwitchCy = `RS485_SWITCH_CYCLES;

  logic     clk;
  logic     rst_n;
  logic     tx_req;
  tx_byte_t tx_data;
  logic     tx_ack;
  logic     rx_req;
  rx_word_t rx_word;
  logic     rx_ack;
  logic     rx_enable;
  logic     di;
  logic     de;
  logic     ren;
  logic     ro;
  int       errors;
  int       tests_run;
  int       tests_failed;
  int       rx_rises;
  int       de_falls;
  logic     req_prev;
  logic     de_prev;

  rs485_uart_top dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .tx_req_i    (tx_req),
    .tx_data_i   (tx_data),
    .tx_ack_o    (tx_ack),
    .rx_req_o    (rx_req),
    .rx_word_o   (rx_word),
    .rx_ack_i    (rx_ack),
    .rx_enable_i (rx_enable),
    .di_o        (di),
    .de_o        (de),
    .ren_o       (ren),
    .ro_i        (ro)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // outputs are sampled on the falling edge, half a cycle after they change
  always @(negedge clk) begin
    if (rst_n) begin
      // the transceiver must be driving whenever the data pin is low
      assert (de || di) else begin
        $display("ERR de_o low while di_o low: de_o=%h di_o=%h", de, di);
        errors++;
      end
      if (rx_req && !req_prev) rx_rises++;
      if (!de && de_prev) de_falls++;
    end
    req_prev = rx_req;
    de_prev  = de;
  end

  function automatic logic [7:0] random_byte();
    logic [31:0] r;
    r = $urandom;
    return r[7:0];
  endfunction

  // four-phase send, ack must not come before a whole 10-bit frame has gone out
  task automatic send_byte(input logic [7:0] data);
    int n;
    @(posedge clk);
    tx_req  <= 1'b1;
    tx_data <= '{data: data};
    n = 0;
    while (!tx_ack && n < 12 * Cpb) begin
      @(negedge clk);
      n++;
    end
    assert (tx_ack) else begin
      $display("timeout waiting for tx_ack_o to rise");
      errors++;
    end
    assert (n >= 10 * Cpb) else begin
      $display("ERR tx_ack_o early: rose after %h cycles, expected at least %h", n, 10 * Cpb);
      errors++;
    end
    @(posedge clk);
    tx_req <= 1'b0;
    n = 0;
    while (tx_ack && n < 8) begin
      @(negedge clk);
      n++;
    end
    assert (!tx_ack) else begin
      $display("timeout waiting for tx_ack_o to fall");
      errors++;
    end
  endtask

  // four-phase receive, the word is captured while req is high
  task automatic take_word(output rx_word_t w);
    int n;
    n = 0;
    while (!rx_req && n < 14 * Cpb) begin
      @(negedge clk);
      n++;
    end
    assert (rx_req) else begin
      $display("timeout waiting for rx_req_o to rise");
      errors++;
    end
    w = rx_word;
    @(posedge clk);
    rx_ack <= 1'b1;
    n = 0;
    while (rx_req && n < 8) begin
      @(negedge clk);
      n++;
    end
    assert (!rx_req) else begin
      $display("timeout waiting for rx_req_o to fall");
      errors++;
    end
    @(posedge clk);
    rx_ack <= 1'b0;
  endtask

  // remote node sending one frame, LSB first, stop level chosen by the caller
  task automatic drive_frame(input logic [7:0] data, input logic stop);
    logic [9:0] bits;
    int         i;
    bits = {stop, data, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(posedge clk);
      ro <= bits[i];
      repeat (Cpb - 1) @(posedge clk);
    end
    @(posedge clk);
    ro <= 1'b1;
  endtask

  task automatic drive_noise(input int cycles);
    logic [31:0] r;
    repeat (cycles) begin
      @(posedge clk);
      r = $urandom;
      ro <= r[0];
    end
    @(posedge clk);
    ro <= 1'b1;
  endtask

  // finds the start edge on di_o and samples each bit in its middle
  task automatic decode_frame(output logic [7:0] data);
    logic [9:0] bits;
    int         n;
    int         i;
    bits = '1;
    n    = 0;
    while (di && n < 14 * Cpb) begin
      @(negedge clk);
      n++;
    end
    assert (!di) else begin
      $display("timeout waiting for a start bit on di_o");
      errors++;
    end
    if (!di) begin
      repeat (Cpb / 2) @(negedge clk);
      bits[0] = di;
      for (i = 1; i < 10; i++) begin
        repeat (Cpb) @(negedge clk);
        bits[i] = di;
      end
      assert (bits[0] == 1'b0 && bits[9] == 1'b1) else begin
        $display("ERR di_o framing: start %h stop %h, expected 0 and 1", bits[0], bits[9]);
        errors++;
      end
    end
    data = bits[8:1];
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
    assert (got == exp) else begin
      $display("ERR di_o data: got %h expected %h", got, exp);
      errors++;
    end
  endtask

  task automatic check_word(input rx_word_t w, input logic [7:0] data, input logic ferr,
                            input logic ovr);
    assert (w.data == data) else begin
      $display("ERR rx_word_o.data: got %h expected %h", w.data, data);
      errors++;
    end
    assert (w.frame_err == ferr) else begin
      $display("ERR rx_word_o.frame_err: got %h expected %h", w.frame_err, ferr);
      errors++;
    end
    assert (w.overrun == ovr) else begin
      $display("ERR rx_word_o.overrun: got %h expected %h", w.overrun, ovr);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - errs_before);
    end
  endtask

  initial begin
    logic [7:0] b;
    logic [7:0] b2;
    logic [7:0] got;
    logic [7:0] got2;
    rx_word_t   w;
    int         mark;
    int         n;
    int         waited;
    int         i;
    tx_req       = 1'b0;
    tx_data      = '0;
    rx_ack       = 1'b0;
    rx_enable    = 1'b0;
    ro           = 1'b1;
    rst_n        = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rx_rises     = 0;
    de_falls     = 0;
    req_prev     = 1'b0;
    de_prev      = 1'b0;
    waited       = 0;
    void'($urandom(32'h1033_c462));
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    mark = errors;
    assert (!tx_ack && !rx_req && !de && ren && di) else begin
      $display("ERR reset values: tx_ack_o=%h rx_req_o=%h de_o=%h ren_o=%h di_o=%h",
               tx_ack, rx_req, de, ren, di);
      errors++;
    end
    end_test("reset values", mark);
    @(posedge clk);
    rx_enable <= 1'b1;

    mark = errors;
    for (i = 0; i < 4; i++) begin
      b = random_byte();
      fork
        send_byte(b);
        decode_frame(got);
      join
      check_byte(got, b);
    end
    end_test("transmit frames", mark);

    // noise starts only once the driver is on, so the gating alone must hide it
    mark = errors;
    n    = rx_rises;
    b    = random_byte();
    fork
      send_byte(b);
      decode_frame(got);
      begin
        waited = 0;
        while (!de && waited < 12 * Cpb) begin
          @(negedge clk);
          waited++;
        end
        assert (de) else begin
          $display("timeout waiting for de_o to rise before the noise burst");
          errors++;
        end
        drive_noise(10 * Cpb);
      end
    join
    check_byte(got, b);
    repeat (12 * Cpb) @(negedge clk);
    assert (rx_rises == n) else begin
      $display("ERR rx_req_o rises during own transmission: got %h expected %h", rx_rises, n);
      errors++;
    end
    end_test("loop-back gating", mark);

    mark = errors;
    n    = 0;
    while (de && n < 20 * Cpb) begin
      @(negedge clk);
      n++;
    end
    assert (!de) else begin
      $display("timeout waiting for de_o to fall");
      errors++;
    end
    repeat (SwitchCy + 2) @(negedge clk);
    assert (ren == 1'b0) else begin
      $display("ERR ren_o in idle: got %h expected 0", ren);
      errors++;
    end
    for (i = 0; i < 4; i++) begin
      b = random_byte();
      fork
        drive_frame(b, 1'b1);
        take_word(w);
      join
      check_word(w, b, 1'b0, 1'b0);
    end
    end_test("receive frames", mark);

    mark = errors;
    b    = random_byte();
    fork
      drive_frame(b, 1'b0);
      take_word(w);
    join
    check_word(w, b, 1'b1, 1'b0);
    end_test("framing error", mark);

    // the second frame lands while the first word still waits for the host
    mark = errors;
    b    = random_byte();
    b2   = random_byte();
    drive_frame(b, 1'b1);
    drive_frame(b2, 1'b1);
    repeat (Cpb) @(negedge clk);
    take_word(w);
    check_word(w, b, 1'b0, 1'b1);
    end_test("overrun", mark);

    mark = errors;
    n    = de_falls;
    b    = random_byte();
    b2   = random_byte();
    fork
      begin
        send_byte(b);
        send_byte(b2);
      end
      begin
        decode_frame(got);
        decode_frame(got2);
      end
    join
    check_byte(got, b);
    check_byte(got2, b2);
    assert (de_falls == n && de) else begin
      $display("ERR de_o dropped between frames: falls %h expected %h", de_falls - n, 0);
      errors++;
    end
    end_test("back-to-back transmit", mark);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end
endmodule
